//--- all.f
+incdir+.
cpu_pkg.sv
decode_stage.sv
reg_file.sv
alu.sv
hazard_unit.sv
cpu_top.sv
tb_cpu.sv

//--- cpu_golden.txt
# I <instruction word>, one per word from address 0
# D <byte address> <initial data word>, S <byte address> <expected store data>
D 00000080 12345678
D 00000084 80000001
# Loads, load-use add, R-type group
I 08002083
I 08402103
I 002081B3
I 10302023
I 40208233
I 00400313
I 406152B3
I 0042C3B3
I 10702223
I 0020B433
I 0020A4B3
I 00609533
I 006155B3
I 00B56633
I 001676B3
I 00868733
I 00970733
I 10E02423
# I-type group
I FFF08793
I 0F07F813
I 70086893
I FFF8C913
I 00391993
I 4089DA13
I 01C9DA93
I FC5A2B13
I 010ABB93
I 015A0C33
I 016C0C33
I 017C0C33
I 11802623
# x0 write, load-store copy, checksum
I 05500013
I 10002823
I 08002C83
I 11902A23
I 10402D03
I 003D0DB3
I 11B02C23
I 00000013
I 00000013
S 00000100 92345679
S 00000104 6A345677
S 00000108 02044601
S 0000010C FFFFFFD5
S 00000110 00000000
S 00000114 12345678
S 00000118 FC68ACF0

//--- tb_cpu.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module tb_cpu;

    localparam int mem_words = 1 << (`CPU_ADDR_W - 2);
    localparam int drain_cycles = 10;

    logic                   clk;
    logic                   rst_n;
    logic [`CPU_XLEN-1:0]   doa;
    logic [`CPU_XLEN-1:0]   dob;
    logic [`CPU_ADDR_W-1:0] addra;
    logic [`CPU_ADDR_W-1:0] addrb;
    logic [`CPU_WE_W-1:0]   web;
    logic [`CPU_XLEN-1:0]   dib;

    logic [`CPU_XLEN-1:0]   imem [mem_words];
    logic [`CPU_XLEN-1:0]   dmem [mem_words];
    logic [`CPU_XLEN-1:0]   exp_addr [$];
    logic [`CPU_XLEN-1:0]   exp_data [$];

    int   errors;
    int   n_prog;
    int   store_idx;
    int   cycles;
    int   limit;
    logic was_in_reset;
    logic first_edge_seen;

    cpu_top i_cpu_top (
        .clk   (clk),
        .rst_n (rst_n),
        .doa   (doa),
        .dob   (dob),
        .addra (addra),
        .addrb (addrb),
        .web   (web),
        .dib   (dib)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("[ERROR] %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    // Tags: I word, D addr value, S addr value, # comment
    task automatic load_golden();
        int                fd;
        int                rc;
        logic [7:0]        tag;
        logic [31:0]       a;
        logic [31:0]       v;
        logic [8*160-1:0]  rest;
        fd = $fopen("cpu_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open cpu_golden.txt for reading");
            return;
        end
        while (!$feof(fd)) begin
            rc = $fscanf(fd, " %c", tag);
            if (rc != 1) begin
                break;
            end
            case (tag)
                "#": rc = $fgets(rest, fd);
                "I": begin
                    rc = $fscanf(fd, " %h", v);
                    imem[n_prog] = v;
                    n_prog++;
                end
                "D": begin
                    rc = $fscanf(fd, " %h %h", a, v);
                    dmem[a[`CPU_ADDR_W-1:2]] = v;
                end
                "S": begin
                    rc = $fscanf(fd, " %h %h", a, v);
                    exp_addr.push_back(a);
                    exp_data.push_back(v);
                end
                default: begin
                    errors++;
                    $display("Unknown record tag in cpu_golden.txt");
                    rc = $fgets(rest, fd);
                end
            endcase
        end
        $fclose(fd);
    endtask

    // Both RAMs, one-cycle registered read
    always @(posedge clk) begin
        doa <= imem[addra[`CPU_ADDR_W-1:2]];
        dob <= dmem[addrb[`CPU_ADDR_W-1:2]];
        if (web == '1) begin
            dmem[addrb[`CPU_ADDR_W-1:2]] <= dib;
        end
    end

    // The synchronous reset only takes hold at the first rising edge
    always @(posedge clk) begin
        first_edge_seen <= 1'b1;
    end

    always @(negedge clk) begin
        if (first_edge_seen && (!rst_n || was_in_reset)) begin
            assert (web == '0) else report_mismatch("web", 32'(web), 32'h0);
            assert (addra == '0) else report_mismatch("addra", 32'(addra), 32'h0);
        end
        if (rst_n) begin
            assert (addra[1:0] == 2'b00) else report_mismatch("addra[1:0]", 32'(addra[1:0]), 0);
            assert (web == '0 || web == '1) else report_mismatch("web", 32'(web), 32'hf);
            if (web != '0) begin
                assert (addrb[1:0] == 2'b00)
                    else report_mismatch("addrb[1:0]", 32'(addrb[1:0]), 0);
                if (store_idx < exp_addr.size()) begin
                    assert (32'(addrb) === exp_addr[store_idx])
                        else report_mismatch("addrb", 32'(addrb), exp_addr[store_idx]);
                    assert (dib === exp_data[store_idx])
                        else report_mismatch("dib", dib, exp_data[store_idx]);
                end else begin
                    errors++;
                    $display("Store to %h beyond the expected sequence", addrb);
                end
                store_idx++;
            end
        end
        was_in_reset = !rst_n;
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        doa = '0;
        dob = '0;
        errors = 0;
        n_prog = 0;
        store_idx = 0;
        cycles = 0;
        was_in_reset = 1'b1;
        first_edge_seen = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            // Unused code words decode as bubbles
            imem[i] = {i[24:0], 7'h7f};
            dmem[i] = 32'hda7a0000 ^ i;
        end
        load_golden();
        limit = 8 * n_prog + 50;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        while (store_idx < exp_addr.size() && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (store_idx < exp_addr.size()) begin
            errors++;
            $display("Timeout after %0d cycles, %0d of %0d stores seen", cycles, store_idx,
                     exp_addr.size());
        end

        // Catch stray stores after the last one
        repeat (drain_cycles) @(posedge clk);
        assert (store_idx == exp_addr.size())
            else report_mismatch("store count", store_idx, exp_addr.size());

        $display("Errors: %0d, stores seen: %0d of %0d, cycles: %0d", errors, store_idx,
                 exp_addr.size(), cycles);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- cpu_top.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_XLEN-1:0]   doa,
    input  logic [`CPU_XLEN-1:0]   dob,
    output logic [`CPU_ADDR_W-1:0] addra,
    output logic [`CPU_ADDR_W-1:0] addrb,
    output logic [`CPU_WE_W-1:0]   web,
    output logic [`CPU_XLEN-1:0]   dib
);

    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] id_pc;
    logic                   id_valid;

    cpu_pkg::id_ex_t        ex;
    cpu_pkg::ex_mem_t       mem;
    cpu_pkg::mem_wb_t       wb;

    cpu_pkg::ctrl_t         dec_ctrl;
    cpu_pkg::ctrl_t         id_ctrl;
    logic [`CPU_XLEN-1:0]   id_imm;
    logic [`CPU_REG_AW-1:0] id_rs1;
    logic [`CPU_REG_AW-1:0] id_rs2;
    logic [`CPU_REG_AW-1:0] id_rd;
    logic [`CPU_XLEN-1:0]   id_rs1_data;
    logic [`CPU_XLEN-1:0]   id_rs2_data;

    cpu_pkg::fwd_sel_e      fwd_a;
    cpu_pkg::fwd_sel_e      fwd_b;
    logic                   mem_store_fwd;
    logic                   stall;
    logic [`CPU_XLEN-1:0]   op_a;
    logic [`CPU_XLEN-1:0]   op_b_reg;
    logic [`CPU_XLEN-1:0]   op_b;
    logic [`CPU_XLEN-1:0]   alu_result;
    logic [`CPU_XLEN-1:0]   wb_data;

    function automatic logic [`CPU_XLEN-1:0] fwd_mux(
        input cpu_pkg::fwd_sel_e    sel,
        input logic [`CPU_XLEN-1:0] reg_data,
        input logic [`CPU_XLEN-1:0] mem_data,
        input logic [`CPU_XLEN-1:0] wb_fwd
    );
        case (sel)
            cpu_pkg::FWD_MEM: return mem_data;
            cpu_pkg::FWD_WB:  return wb_fwd;
            default:          return reg_data;
        endcase
    endfunction

    // A stall refetches the ID word so it shows up on doa again
    assign addra = stall ? id_pc : pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= `CPU_ADDR_W'(`CPU_RESET_PC);
            id_pc    <= `CPU_ADDR_W'(`CPU_RESET_PC);
            id_valid <= 1'b0;
        end else begin
            // doa is stale on the first cycle out of reset
            id_valid <= 1'b1;
            if (!stall) begin
                pc    <= pc + `CPU_ADDR_W'(4);
                id_pc <= pc;
            end
        end
    end

    assign id_rs1  = doa[19:15];
    assign id_rs2  = doa[24:20];
    assign id_rd   = doa[11:7];
    assign id_ctrl = id_valid ? dec_ctrl : '0;

    decode_stage i_decode_stage (
        .instr (doa),
        .ctrl  (dec_ctrl),
        .imm   (id_imm)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (id_rs1),
        .rs2      (id_rs2),
        .rd       (wb.rd),
        .we       (wb.reg_write),
        .wdata    (wb_data),
        .rs1_data (id_rs1_data),
        .rs2_data (id_rs2_data)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex.ctrl <= '0;
        end else begin
            ex.ctrl     <= stall ? '0 : id_ctrl;
            ex.rs1      <= id_rs1;
            ex.rs2      <= id_rs2;
            ex.rd       <= id_rd;
            ex.rs1_data <= id_rs1_data;
            ex.rs2_data <= id_rs2_data;
            ex.imm      <= id_imm;
        end
    end

    assign op_a     = fwd_mux(fwd_a, ex.rs1_data, mem.alu_result, wb_data);
    assign op_b_reg = fwd_mux(fwd_b, ex.rs2_data, mem.alu_result, wb_data);
    assign op_b     = ex.ctrl.alu_src ? ex.imm : op_b_reg;

    alu i_alu (
        .op     (ex.ctrl.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem.reg_write <= 1'b0;
            mem.mem_read  <= 1'b0;
            mem.mem_write <= 1'b0;
        end else begin
            mem.reg_write  <= ex.ctrl.reg_write;
            mem.mem_read   <= ex.ctrl.mem_read;
            mem.mem_write  <= ex.ctrl.mem_write;
            mem.rs2        <= ex.rs2;
            mem.rd         <= ex.rd;
            mem.alu_result <= alu_result;
            mem.rs2_data   <= op_b_reg;
        end
    end

    assign addrb = mem.alu_result[`CPU_ADDR_W-1:0];
    assign web   = {`CPU_WE_W{mem.mem_write}};
    assign dib   = mem_store_fwd ? wb_data : mem.rs2_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.reg_write <= 1'b0;
            wb.mem_read  <= 1'b0;
        end else begin
            wb.reg_write  <= mem.reg_write;
            wb.mem_read   <= mem.mem_read;
            wb.rd         <= mem.rd;
            wb.alu_result <= mem.alu_result;
        end
    end

    // Load data arrives from the RAM during WB
    assign wb_data = wb.mem_read ? dob : wb.alu_result;

    hazard_unit i_hazard_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .id_ctrl       (id_ctrl),
        .ex            (ex),
        .mem           (mem),
        .wb            (wb),
        .wb_data       (wb_data),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .mem_store_fwd (mem_store_fwd),
        .stall         (stall)
    );

    // Only word stores exist
    store_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (web != '0) |-> (addrb[1:0] == 2'b00));

endmodule

//--- hazard_unit.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module hazard_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_REG_AW-1:0] id_rs1,
    input  logic [`CPU_REG_AW-1:0] id_rs2,
    input  cpu_pkg::ctrl_t         id_ctrl,
    input  cpu_pkg::id_ex_t        ex,
    input  cpu_pkg::ex_mem_t       mem,
    input  cpu_pkg::mem_wb_t       wb,
    input  logic [`CPU_XLEN-1:0]   wb_data,
    output cpu_pkg::fwd_sel_e      fwd_a,
    output cpu_pkg::fwd_sel_e      fwd_b,
    output logic                   mem_store_fwd,
    output logic                   stall
);

    logic id_uses_rs1;
    logic id_uses_rs2;
    logic load_in_ex;

    // A load in MEM has no data yet, the stall or the store path covers it
    function automatic cpu_pkg::fwd_sel_e src_sel(input logic [`CPU_REG_AW-1:0] src);
        if (src != '0 && mem.reg_write && !mem.mem_read && mem.rd == src) begin
            return cpu_pkg::FWD_MEM;
        end
        if (src != '0 && wb.reg_write && wb.rd == src) begin
            return cpu_pkg::FWD_WB;
        end
        return cpu_pkg::FWD_NONE;
    endfunction

    assign fwd_a = src_sel(ex.rs1);
    assign fwd_b = src_sel(ex.rs2);

    // Store right behind the load it copies
    assign mem_store_fwd = mem.mem_write && wb.reg_write && wb.mem_read
                           && wb.rd != '0 && wb.rd == mem.rs2;

    // rs2 of a store is excluded through alu_src
    assign id_uses_rs1 = id_ctrl.reg_write || id_ctrl.mem_write;
    assign id_uses_rs2 = id_uses_rs1 && !id_ctrl.alu_src;
    assign load_in_ex  = ex.ctrl.mem_read && ex.rd != '0;

    assign stall = load_in_ex && ((id_uses_rs1 && ex.rd == id_rs1)
                                  || (id_uses_rs2 && ex.rd == id_rs2));

    single_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !stall);

    store_fwd_known: assert property (@(posedge clk) disable iff (!rst_n)
        mem_store_fwd |-> !$isunknown(wb_data));

endmodule

//--- alu.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module alu (
    input  cpu_pkg::alu_op_e     op,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    output logic [`CPU_XLEN-1:0] result
);

    logic [4:0] shamt;

    // Only the low bits of b count for shifts
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: begin
                result = a + b;
            end
            cpu_pkg::ALU_SUB: begin
                result = a - b;
            end
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_OR:  result = a | b;
            cpu_pkg::ALU_XOR: result = a ^ b;
            cpu_pkg::ALU_SLL: result = a << shamt;
            cpu_pkg::ALU_SRL: result = a >> shamt;
            cpu_pkg::ALU_SRA: begin
                result = $signed(a) >>> shamt;
            end
            cpu_pkg::ALU_SLT: begin
                result = `CPU_XLEN'($signed(a) < $signed(b));
            end
            cpu_pkg::ALU_SLTU: begin
                result = `CPU_XLEN'(a < b);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- reg_file.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_REG_AW-1:0] rs1,
    input  logic [`CPU_REG_AW-1:0] rs2,
    input  logic [`CPU_REG_AW-1:0] rd,
    input  logic                   we,
    input  logic [`CPU_XLEN-1:0]   wdata,
    output logic [`CPU_XLEN-1:0]   rs1_data,
    output logic [`CPU_XLEN-1:0]   rs2_data
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NUM_REGS];

    // Write-first, so WB and ID can share a cycle
    function automatic logic [`CPU_XLEN-1:0] read_port(input logic [`CPU_REG_AW-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (we && rd == idx) begin
            return wdata;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);

    x0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n)
        we |=> (regs[0] == '0));

endmodule

//--- decode_stage.sv
`timescale 1ns/10ps
`include "cpu_consts.svh"

module decode_stage (
    input  logic [`CPU_XLEN-1:0] instr,
    output cpu_pkg::ctrl_t       ctrl,
    output logic [`CPU_XLEN-1:0] imm
);

    cpu_pkg::opcode_e opcode;
    cpu_pkg::alu_op_e alu_sel;
    logic [2:0]       funct3;
    logic             alt;
    logic             is_reg;

    assign opcode = cpu_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = instr[30];
    assign is_reg = (opcode == cpu_pkg::OP_R_ALU);

    // S-type splits the offset around rd
    assign imm = (opcode == cpu_pkg::OP_STORE)
        ? {{(`CPU_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]}
        : {{(`CPU_XLEN-12){instr[31]}}, instr[31:20]};

    always_comb begin
        case (funct3)
            3'b000: begin
                // Bit 30 is part of the immediate for addi
                alu_sel = (is_reg && alt) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            end
            3'b001: begin
                alu_sel = cpu_pkg::ALU_SLL;
            end
            3'b010: begin
                alu_sel = cpu_pkg::ALU_SLT;
            end
            3'b011: begin
                alu_sel = cpu_pkg::ALU_SLTU;
            end
            3'b100: begin
                alu_sel = cpu_pkg::ALU_XOR;
            end
            3'b101: begin
                alu_sel = alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            end
            3'b110: begin
                alu_sel = cpu_pkg::ALU_OR;
            end
            default: begin
                alu_sel = cpu_pkg::ALU_AND;
            end
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            cpu_pkg::OP_R_ALU: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_sel;
            end
            cpu_pkg::OP_I_ALU: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_sel;
            end
            cpu_pkg::OP_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = cpu_pkg::ALU_ADD;
            end
            cpu_pkg::OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = cpu_pkg::ALU_ADD;
            end
            default: begin
                // Anything else passes through as a bubble
                ctrl = '0;
            end
        endcase
    end

endmodule

//--- cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

    // RISC-V major opcodes of the supported groups
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_I_ALU = 7'b0010011,
        OP_STORE = 7'b0100011,
        OP_R_ALU = 7'b0110011
    } opcode_e;

    // ALU_ADD is zero so that a cleared control word is a plain add
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // EX operand source
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`CPU_REG_AW-1:0] rs1;
        logic [`CPU_REG_AW-1:0] rs2;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   rs1_data;
        logic [`CPU_XLEN-1:0]   rs2_data;
        logic [`CPU_XLEN-1:0]   imm;
    } id_ex_t;

    typedef struct packed {
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic [`CPU_REG_AW-1:0] rs2;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   alu_result;
        logic [`CPU_XLEN-1:0]   rs2_data;
    } ex_mem_t;

    typedef struct packed {
        logic                   reg_write;
        logic                   mem_read;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   alu_result;
    } mem_wb_t;

endpackage

//--- cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path and instruction width
`define CPU_XLEN 32

// Byte address width of both RAM ports
`define CPU_ADDR_W 16

// Register index width and count
`define CPU_REG_AW 5
`define CPU_NUM_REGS 32

// One write enable per byte lane of the data port
`define CPU_WE_W 4

// First fetch address out of reset
`define CPU_RESET_PC 0

`endif
